//--- pp_api.f
verilog/pp_api_pkg.sv
verilog/pp_api_wb_slave.sv
verilog/pp_mac_bank.sv
verilog/pp_ipv4_bank.sv
verilog/pp_ipv6_bank.sv
verilog/pp_api.sv
dv/pp_api_tb.sv

//--- Makefile
# Verilator flow for pp_api: lint the RTL, build and run the testbench, clean up

VERILATOR ?= verilator
TOP       ?= pp_api_tb
RTL_TOP   ?= pp_api
FILELIST  ?= pp_api.f
OBJ_DIR   ?= obj_dir
SEED_LOG  ?= sim.log
SIM_FLAGS ?= --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The run passes only when the log holds the pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(SEED_LOG)
	@grep -q "^RESULT: PASS$$" $(SEED_LOG) || \
		(echo "Simulation failed, see $(SEED_LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

//--- dv/pp_api_tb.sv
// Self-checking testbench for pp_api that runs Wishbone traffic against a register model
`timescale 1ns/1ps

module pp_api_tb;

  localparam int ACK_TIMEOUT = 20;
  localparam int NUM_RANDOM  = 400;

  logic                    clk;
  logic                    areset;
  logic                    cyc;
  logic                    stb;
  logic                    we;
  pp_api_pkg::reg_addr_t   adr;
  pp_api_pkg::word_t       dat_w;
  pp_api_pkg::word_t       dat_r;
  logic                    ack;
  pp_api_pkg::mac_table_t  mac_table;
  pp_api_pkg::ipv4_table_t ipv4_table;
  pp_api_pkg::ipv6_table_t ipv6_table;

  // Request left on the bus by the previous access
  logic                    req_held;

  // Register model
  pp_api_pkg::word_t model_mac_low  [pp_api_pkg::MAC_COUNT];
  logic [15:0]       model_mac_high [pp_api_pkg::MAC_COUNT];
  pp_api_pkg::word_t model_ipv4     [pp_api_pkg::IPV4_COUNT];
  pp_api_pkg::word_t model_ipv6     [pp_api_pkg::IPV6_COUNT][pp_api_pkg::IPV6_WORDS];

  pp_api UUT (
    .clk        (clk),
    .areset     (areset),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .dat_r      (dat_r),
    .ack        (ack),
    .mac_table  (mac_table),
    .ipv4_table (ipv4_table),
    .ipv6_table (ipv6_table)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // Error handling
  // ------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected)
      abort_run($sformatf("ERROR: %s actual 0x%0h expected 0x%0h", name, actual, expected));
  endtask

  // ------------------------------
  // Register model
  // ------------------------------
  function automatic pp_api_pkg::word_t model_read(input pp_api_pkg::reg_addr_t a);
    int mac_off;
    int ipv4_off;
    int ipv6_off;
    mac_off  = int'(a) - 'h040;
    ipv4_off = int'(a) - 'h050;
    ipv6_off = int'(a) - 'h060;
    if (a == 12'h000)
      return 32'h7070_5f61;
    if (a == 12'h001)
      return 32'h7069_2020;
    if (a == 12'h002)
      return 32'h302e_3130;
    if (mac_off >= 0 && mac_off < 8)
    begin
      if (mac_off % 2 == 1)
        return {16'h0000, model_mac_high[mac_off / 2]};
      return model_mac_low[mac_off / 2];
    end
    if (ipv4_off >= 0 && ipv4_off < 8)
      return model_ipv4[ipv4_off];
    if (ipv6_off >= 0 && ipv6_off < 32)
      return model_ipv6[ipv6_off / 4][ipv6_off % 4];
    return 32'h553b_a553;
  endfunction

  // Identity and unmapped writes fall through every branch
  task automatic model_write(input pp_api_pkg::reg_addr_t a, input pp_api_pkg::word_t d);
    int mac_off;
    int ipv4_off;
    int ipv6_off;
    mac_off  = int'(a) - 'h040;
    ipv4_off = int'(a) - 'h050;
    ipv6_off = int'(a) - 'h060;
    if (mac_off >= 0 && mac_off < 8)
    begin
      if (mac_off % 2 == 1)
        model_mac_high[mac_off / 2] = d[15:0];
      else
        model_mac_low[mac_off / 2] = d;
    end
    else if (ipv4_off >= 0 && ipv4_off < 8)
      model_ipv4[ipv4_off] = d;
    else if (ipv6_off >= 0 && ipv6_off < 32)
      model_ipv6[ipv6_off / 4][ipv6_off % 4] = d;
  endtask

  task automatic check_tables();
    for (int i = 0; i < pp_api_pkg::MAC_COUNT; i++)
      check_value($sformatf("mac_table[%0d]", i), 128'(mac_table[i]),
                  128'({model_mac_high[i], model_mac_low[i]}));
    for (int i = 0; i < pp_api_pkg::IPV4_COUNT; i++)
      check_value($sformatf("ipv4_table[%0d]", i), 128'(ipv4_table[i]), 128'(model_ipv4[i]));
    for (int i = 0; i < pp_api_pkg::IPV6_COUNT; i++)
      check_value($sformatf("ipv6_table[%0d]", i), ipv6_table[i],
                  {model_ipv6[i][3], model_ipv6[i][2], model_ipv6[i][1], model_ipv6[i][0]});
  endtask

  // ------------------------------
  // Wishbone driver
  // ------------------------------
  // Starts and ends on a falling edge
  task automatic bus_access(input logic write, input pp_api_pkg::reg_addr_t a,
                            input pp_api_pkg::word_t d, output pp_api_pkg::word_t rdata);
    int waited;
    int idle;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    dat_w = d;
    @(negedge clk);
    waited = 1;
    while (ack !== 1'b1 && waited < ACK_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (ack !== 1'b1)
      abort_run("No acknowledge from slave within 20 cycles");
    // A still pending ack holds off acceptance by one edge
    check_value("ack latency", 128'(waited), req_held ? 128'd2 : 128'd1);
    rdata = dat_r;
    if (write)
    begin
      model_write(a, d);
      check_tables();
    end
    idle = $urandom_range(3, 0);
    req_held = (idle == 0);
    if (idle > 0)
    begin
      cyc = 1'b0;
      stb = 1'b0;
      @(negedge clk);
      check_value("ack", 128'(ack), 128'd0);
      repeat (idle - 1) @(negedge clk);
    end
  endtask

  task automatic read_check(input pp_api_pkg::reg_addr_t a);
    pp_api_pkg::word_t rdata;
    bus_access(1'b0, a, '0, rdata);
    check_value($sformatf("dat_r at 0x%03h", a), 128'(rdata), 128'(model_read(a)));
  endtask

  task automatic write_word(input pp_api_pkg::reg_addr_t a, input pp_api_pkg::word_t d);
    pp_api_pkg::word_t rdata;
    bus_access(1'b1, a, d, rdata);
  endtask

  // Mostly mapped addresses with a quarter from the whole space
  function automatic pp_api_pkg::reg_addr_t random_addr();
    int pick;
    pick = $urandom_range(7, 0);
    case (pick)
      0:       return 12'(12'h000 + $urandom_range(2, 0));
      1, 2:    return 12'(12'h040 + $urandom_range(7, 0));
      3:       return 12'(12'h050 + $urandom_range(7, 0));
      4, 5:    return 12'(12'h060 + $urandom_range(31, 0));
      default: return 12'($urandom());
    endcase
  endfunction

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    pp_api_pkg::reg_addr_t a;
    pp_api_pkg::word_t     d;
    void'($urandom(32'h59ea_5550));
    areset   = 1'b1;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    dat_w    = '0;
    req_held = 1'b0;
    for (int i = 0; i < pp_api_pkg::MAC_COUNT; i++)
    begin
      model_mac_low[i]  = '0;
      model_mac_high[i] = '0;
    end
    for (int i = 0; i < pp_api_pkg::IPV4_COUNT; i++)
      model_ipv4[i] = '0;
    for (int i = 0; i < pp_api_pkg::IPV6_COUNT; i++)
      for (int j = 0; j < pp_api_pkg::IPV6_WORDS; j++)
        model_ipv6[i][j] = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    areset = 1'b0;
    @(negedge clk);

    // Reset state of the handshake, tables and every mapped word
    check_value("ack", 128'(ack), 128'd0);
    check_tables();
    for (int i = 0; i < 8; i++)
      read_check(12'(12'h040 + i));
    for (int i = 0; i < 8; i++)
      read_check(12'(12'h050 + i));
    for (int i = 0; i < 32; i++)
      read_check(12'(12'h060 + i));

    // Identity words ignore writes
    for (int i = 0; i < 3; i++)
    begin
      read_check(12'(i));
      write_word(12'(i), $urandom());
      read_check(12'(i));
    end

    // Random traffic with some writes read back at once
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      a = random_addr();
      d = $urandom();
      if ($urandom_range(1, 0) == 1)
      begin
        write_word(a, d);
        if ($urandom_range(1, 0) == 1)
          read_check(a);
      end
      else
        read_check(a);
    end

    cyc = 1'b0;
    stb = 1'b0;
    @(negedge clk);
    check_value("ack", 128'(ack), 128'd0);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- verilog/pp_api.sv
// Top of the pp_api register block, Wishbone slave feeding the address banks
`timescale 1ns/1ps

module pp_api (
  input  logic                    clk,
  input  logic                    areset,

  // Wishbone classic slave port
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  pp_api_pkg::reg_addr_t   adr,
  input  pp_api_pkg::word_t       dat_w,
  output pp_api_pkg::word_t       dat_r,
  output logic                    ack,

  // Address tables for the packet datapath
  output pp_api_pkg::mac_table_t  mac_table,
  output pp_api_pkg::ipv4_table_t ipv4_table,
  output pp_api_pkg::ipv6_table_t ipv6_table
);

  pp_api_pkg::reg_access_t access;
  pp_api_pkg::word_t       mac_rd_data;
  pp_api_pkg::word_t       ipv4_rd_data;
  pp_api_pkg::word_t       ipv6_rd_data;
  logic                    mac_we;
  logic                    ipv4_we;
  logic                    ipv6_we;

  // ------------------------------
  // Bus slave
  // ------------------------------
  pp_api_wb_slave u_wb_slave (
    .clk          (clk),
    .areset       (areset),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .dat_w        (dat_w),
    .mac_rd_data  (mac_rd_data),
    .ipv4_rd_data (ipv4_rd_data),
    .ipv6_rd_data (ipv6_rd_data),
    .dat_r        (dat_r),
    .ack          (ack),
    .access       (access),
    .mac_we       (mac_we),
    .ipv4_we      (ipv4_we),
    .ipv6_we      (ipv6_we)
  );

  // ------------------------------
  // Address banks
  // ------------------------------
  pp_mac_bank u_mac_bank (
    .clk       (clk),
    .areset    (areset),
    .access    (access),
    .we        (mac_we),
    .rd_data   (mac_rd_data),
    .mac_table (mac_table)
  );

  pp_ipv4_bank u_ipv4_bank (
    .clk        (clk),
    .areset     (areset),
    .access     (access),
    .we         (ipv4_we),
    .rd_data    (ipv4_rd_data),
    .ipv4_table (ipv4_table)
  );

  pp_ipv6_bank u_ipv6_bank (
    .clk        (clk),
    .areset     (areset),
    .access     (access),
    .we         (ipv6_we),
    .rd_data    (ipv6_rd_data),
    .ipv6_table (ipv6_table)
  );

endmodule

//--- verilog/pp_ipv6_bank.sv
// IPv6 address bank of pp_api, eight addresses of four words each
`timescale 1ns/1ps

module pp_ipv6_bank (
  input  logic                    clk,
  input  logic                    areset,
  input  pp_api_pkg::reg_access_t access,
  input  logic                    we,
  output pp_api_pkg::word_t       rd_data,
  output pp_api_pkg::ipv6_table_t ipv6_table
);

  // Word 0 of each entry is the least significant
  pp_api_pkg::word_t addr_word [pp_api_pkg::IPV6_COUNT][pp_api_pkg::IPV6_WORDS];

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk or posedge areset)
  begin
    if (areset)
    begin
      for (int i = 0; i < pp_api_pkg::IPV6_COUNT; i++)
      begin
        for (int j = 0; j < pp_api_pkg::IPV6_WORDS; j++)
          addr_word[i][j] <= '0;
      end
    end
    else if (we)
    begin
      addr_word[access.entry][access.word] <= access.data;
    end
  end

  assign rd_data = addr_word[access.entry][access.word];

  // Assemble each 128-bit address with word 3 on top
  always_comb
  begin
    for (int i = 0; i < pp_api_pkg::IPV6_COUNT; i++)
    begin
      for (int j = 0; j < pp_api_pkg::IPV6_WORDS; j++)
        ipv6_table[i][j*32 +: 32] = addr_word[i][j];
    end
  end

endmodule

//--- verilog/pp_ipv4_bank.sv
// IPv4 address bank of pp_api, eight one-word addresses
`timescale 1ns/1ps

module pp_ipv4_bank (
  input  logic                    clk,
  input  logic                    areset,
  input  pp_api_pkg::reg_access_t access,
  input  logic                    we,
  output pp_api_pkg::word_t       rd_data,
  output pp_api_pkg::ipv4_table_t ipv4_table
);

  pp_api_pkg::ipv4_addr_t addr_reg [pp_api_pkg::IPV4_COUNT];

  always_ff @(posedge clk or posedge areset)
  begin
    if (areset)
    begin
      for (int i = 0; i < pp_api_pkg::IPV4_COUNT; i++)
        addr_reg[i] <= '0;
    end
    else if (we)
    begin
      addr_reg[access.entry] <= access.data;
    end
  end

  // Read back the selected entry
  assign rd_data = addr_reg[access.entry];

  always_comb
  begin
    for (int i = 0; i < pp_api_pkg::IPV4_COUNT; i++)
      ipv4_table[i] = addr_reg[i];
  end

endmodule

//--- verilog/pp_mac_bank.sv
// MAC address bank of pp_api, four addresses stored as low and high words
`timescale 1ns/1ps

module pp_mac_bank (
  input  logic                    clk,
  input  logic                    areset,
  input  pp_api_pkg::reg_access_t access,
  input  logic                    we,
  output pp_api_pkg::word_t       rd_data,
  output pp_api_pkg::mac_table_t  mac_table
);

  pp_api_pkg::word_t low_word  [pp_api_pkg::MAC_COUNT];
  logic [15:0]       high_word [pp_api_pkg::MAC_COUNT];
  logic              sel_high;

  // Word 1 of an entry is the high part
  assign sel_high = access.word[0];

  always_ff @(posedge clk or posedge areset)
  begin
    if (areset)
    begin
      for (int i = 0; i < pp_api_pkg::MAC_COUNT; i++)
      begin
        low_word[i]  <= '0;
        high_word[i] <= '0;
      end
    end
    else if (we)
    begin
      if (sel_high)
        high_word[access.entry[1:0]] <= access.data[15:0];
      else
        low_word[access.entry[1:0]] <= access.data;
    end
  end

  // High words read back zero extended
  assign rd_data = sel_high ? {16'h0000, high_word[access.entry[1:0]]}
                            : low_word[access.entry[1:0]];

  always_comb
  begin
    for (int i = 0; i < pp_api_pkg::MAC_COUNT; i++)
      mac_table[i] = {high_word[i], low_word[i]};
  end

endmodule

//--- verilog/pp_api_wb_slave.sv
// Wishbone classic slave for pp_api, decodes bus cycles into bank accesses
`timescale 1ns/1ps

module pp_api_wb_slave (
  input  logic                    clk,
  input  logic                    areset,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  pp_api_pkg::reg_addr_t   adr,
  input  pp_api_pkg::word_t       dat_w,
  input  pp_api_pkg::word_t       mac_rd_data,
  input  pp_api_pkg::word_t       ipv4_rd_data,
  input  pp_api_pkg::word_t       ipv6_rd_data,
  output pp_api_pkg::word_t       dat_r,
  output logic                    ack,
  output pp_api_pkg::reg_access_t access,
  output logic                    mac_we,
  output logic                    ipv4_we,
  output logic                    ipv6_we
);

  pp_api_pkg::reg_addr_t mac_off;
  pp_api_pkg::reg_addr_t ipv4_off;
  pp_api_pkg::reg_addr_t ipv6_off;
  pp_api_pkg::word_t     rd_word;
  logic                  in_mac;
  logic                  in_ipv4;
  logic                  in_ipv6;
  logic                  accept;

  // ------------------------------
  // Region decode
  // ------------------------------
  // An address below a base wraps to a large offset and falls outside the span
  assign mac_off  = adr - pp_api_pkg::MAC_BASE;
  assign ipv4_off = adr - pp_api_pkg::IPV4_BASE;
  assign ipv6_off = adr - pp_api_pkg::IPV6_BASE;

  assign in_mac  = mac_off < pp_api_pkg::MAC_SPAN;
  assign in_ipv4 = ipv4_off < pp_api_pkg::IPV4_SPAN;
  assign in_ipv6 = ipv6_off < pp_api_pkg::IPV6_SPAN;

  // Split the offset into entry and word for the selected bank
  always_comb
  begin
    access.data  = dat_w;
    access.entry = '0;
    access.word  = '0;
    if (in_mac)
    begin
      access.entry = mac_off[3:1];
      access.word  = {1'b0, mac_off[0]};
    end
    else if (in_ipv4)
    begin
      access.entry = ipv4_off[2:0];
    end
    else if (in_ipv6)
    begin
      access.entry = ipv6_off[4:2];
      access.word  = ipv6_off[1:0];
    end
  end

  // Read data select
  always_comb
  begin
    case (adr)
      pp_api_pkg::ADDR_NAME0:   rd_word = pp_api_pkg::CORE_NAME0;
      pp_api_pkg::ADDR_NAME1:   rd_word = pp_api_pkg::CORE_NAME1;
      pp_api_pkg::ADDR_VERSION: rd_word = pp_api_pkg::CORE_VERSION;
      default:
      begin
        if (in_mac)
          rd_word = mac_rd_data;
        else if (in_ipv4)
          rd_word = ipv4_rd_data;
        else if (in_ipv6)
          rd_word = ipv6_rd_data;
        else
          rd_word = pp_api_pkg::UNMAPPED_READ;
      end
    endcase
  end

  // ------------------------------
  // Handshake
  // ------------------------------
  // A request is taken only while ack is low, so ack lasts one cycle
  assign accept = cyc & stb & ~ack;

  assign mac_we  = accept & we & in_mac;
  assign ipv4_we = accept & we & in_ipv4;
  assign ipv6_we = accept & we & in_ipv6;

  always_ff @(posedge clk or posedge areset)
  begin
    if (areset)
    begin
      ack   <= 1'b0;
      dat_r <= '0;
    end
    else
    begin
      ack <= accept;
      if (accept && !we)
        dat_r <= rd_word;
    end
  end

endmodule

//--- verilog/pp_api_pkg.sv
// Types, address map and identity constants shared by every pp_api block
package pp_api_pkg;

  // ------------------------------
  // Plain vector types
  // ------------------------------
  typedef logic [31:0]  word_t;
  typedef logic [11:0]  reg_addr_t;
  typedef logic [47:0]  mac_addr_t;
  typedef logic [31:0]  ipv4_addr_t;
  typedef logic [127:0] ipv6_addr_t;

  // Position of a register inside a bank
  typedef logic [2:0]   entry_idx_t;
  typedef logic [1:0]   word_idx_t;

  // ------------------------------
  // Table sizes
  // ------------------------------
  localparam int MAC_COUNT  = 4;
  localparam int MAC_WORDS  = 2;
  localparam int IPV4_COUNT = 8;
  localparam int IPV6_COUNT = 8;
  localparam int IPV6_WORDS = 4;

  // Entry 0 sits in the low bits of every table
  typedef mac_addr_t  [MAC_COUNT-1:0]  mac_table_t;
  typedef ipv4_addr_t [IPV4_COUNT-1:0] ipv4_table_t;
  typedef ipv6_addr_t [IPV6_COUNT-1:0] ipv6_table_t;

  // One decoded bus access as seen by a bank
  typedef struct packed {
    entry_idx_t entry;
    word_idx_t  word;
    word_t      data;
  } reg_access_t;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam reg_addr_t ADDR_NAME0   = 12'h000;
  localparam reg_addr_t ADDR_NAME1   = 12'h001;
  localparam reg_addr_t ADDR_VERSION = 12'h002;

  localparam reg_addr_t MAC_BASE  = 12'h040;
  localparam reg_addr_t IPV4_BASE = 12'h050;
  localparam reg_addr_t IPV6_BASE = 12'h060;

  // Region spans in words
  localparam reg_addr_t MAC_SPAN  = reg_addr_t'(MAC_COUNT * MAC_WORDS);
  localparam reg_addr_t IPV4_SPAN = reg_addr_t'(IPV4_COUNT);
  localparam reg_addr_t IPV6_SPAN = reg_addr_t'(IPV6_COUNT * IPV6_WORDS);

  // Identity words in ASCII
  localparam word_t CORE_NAME0    = 32'h7070_5f61;  // pp_a
  localparam word_t CORE_NAME1    = 32'h7069_2020;  // pi
  localparam word_t CORE_VERSION  = 32'h302e_3130;  // 0.10
  localparam word_t UNMAPPED_READ = 32'h553b_a553;

endpackage
